// ==== include/rv64_core_defs.svh ====
`ifndef RV64_CORE_DEFS_SVH
`define RV64_CORE_DEFS_SVH

////////////////////////////////////////
// Core widths and sizes
////////////////////////////////////////

// Integer register and data path width
`define XLEN 64

// Architectural registers, x0 included
`define REG_COUNT 32

// First fetch address out of reset
`define RESET_PC 64'h0000_0000_0000_0000

`endif

// ==== verilog/rv64_core_pkg.sv ====
package rv64_core_pkg;

    ////////////////////////////////////////
    // Major opcodes
    ////////////////////////////////////////
    typedef enum logic [6:0] {
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_BRANCH    = 7'b1100011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP        = 7'b0110011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_OP_32     = 7'b0111011
    } opcode_e;

    // ALU functions, word forms sign-extend from bit 31
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
        ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
        ALU_OR, ALU_AND, ALU_ADDW, ALU_SUBW,
        ALU_SLLW, ALU_SRLW, ALU_SRAW, ALU_PASS2
    } alu_op_e;

    ////////////////////////////////////////
    // Datapath selects
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        OP1_RS1, OP1_PC, OP1_ZERO
    } op1_sel_e;

    typedef enum logic {
        OP2_RS2, OP2_IMM
    } op2_sel_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_MEM, WB_SNPC
    } wb_sel_e;

    // Branch is conditional, JALR clears target bit 0
    typedef enum logic [1:0] {
        NPC_SEQ, NPC_BRANCH, NPC_JAL, NPC_JALR
    } npc_sel_e;

endpackage

// ==== verilog/pc_unit.sv ====
`timescale 1ns/1ps

`include "rv64_core_defs.svh"

module pc_unit (
    input  logic                      sys_clk,
    input  logic                      rst_n,
    input  rv64_core_pkg::npc_sel_e   npc_sel,
    input  logic [2:0]                funct3,
    input  logic [`XLEN-1:0]          rs1_data,
    input  logic [`XLEN-1:0]          rs2_data,
    input  logic [`XLEN-1:0]          target,
    output logic [`XLEN-1:0]          pc,
    output logic [`XLEN-1:0]          snpc
);
    import rv64_core_pkg::*;

    logic               taken;
    logic [`XLEN-1:0]   dnpc;

    assign snpc = pc + `XLEN'd4;

    // Branch condition from funct3
    always_comb begin
        case (funct3)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  taken = (rs1_data < rs2_data);
            3'b111:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (npc_sel)
            NPC_BRANCH: dnpc = taken ? target : snpc;
            NPC_JAL:    dnpc = target;
            NPC_JALR:   dnpc = {target[`XLEN-1:1], 1'b0};
            default:    dnpc = snpc;
        endcase
    end

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n)
            pc <= `RESET_PC;
        else
            pc <= dnpc;
    end

endmodule

// ==== verilog/gpr.sv ====
`timescale 1ns/1ps

`include "rv64_core_defs.svh"

module gpr (
    input  logic                sys_clk,
    input  logic                rst_n,
    input  logic                wen,
    input  logic [4:0]          rd_addr,
    input  logic [`XLEN-1:0]    wr_data,
    input  logic [4:0]          rs1_addr,
    input  logic [4:0]          rs2_addr,
    output logic [`XLEN-1:0]    rs1_data,
    output logic [`XLEN-1:0]    rs2_data
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (rd_addr != 5'd0)) begin
            regs[rd_addr] <= wr_data;
        end
    end

    // Combinational reads, a same-cycle write is not forwarded
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== verilog/decoder.sv ====
`timescale 1ns/1ps

`include "rv64_core_defs.svh"

module decoder (
    input  logic [31:0]              inst,
    output logic [`XLEN-1:0]         imm,
    output logic [4:0]               rs1_addr,
    output logic [4:0]               rs2_addr,
    output logic [4:0]               rd_addr,
    output logic [2:0]               funct3,
    output logic                     reg_wen,
    output logic                     mem_wen,
    output logic                     mem_rd_en,
    output rv64_core_pkg::alu_op_e   alu_op,
    output rv64_core_pkg::op1_sel_e  op1_sel,
    output rv64_core_pkg::op2_sel_e  op2_sel,
    output rv64_core_pkg::wb_sel_e   wb_sel,
    output rv64_core_pkg::npc_sel_e  npc_sel
);
    import rv64_core_pkg::*;

    opcode_e            opcode;
    logic               alt;
    logic [`XLEN-1:0]   imm_i;
    logic [`XLEN-1:0]   imm_s;
    logic [`XLEN-1:0]   imm_b;
    logic [`XLEN-1:0]   imm_u;
    logic [`XLEN-1:0]   imm_j;

    // 64-bit register-width operations
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic sub_alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = sub_alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // 32-bit word operations
    function automatic alu_op_e word_op(input logic [2:0] f3, input logic sub_alt);
        alu_op_e op;
        case (f3)
            3'b001:  op = ALU_SLLW;
            3'b101:  op = alt ? ALU_SRAW : ALU_SRLW;
            default: op = sub_alt ? ALU_SUBW : ALU_ADDW;
        endcase
        return op;
    endfunction

    ////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////
    assign opcode   = opcode_e'(inst[6:0]);
    assign rd_addr  = inst[11:7];
    assign funct3   = inst[14:12];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];
    // funct7 bit 5 picks SUB and arithmetic shifts
    assign alt      = inst[30];

    // Immediates, all sign-extended from inst[31]
    assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                    inst[11:8], 1'b0};
    assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                    inst[30:21], 1'b0};

    ////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////
    always_comb begin
        // No-op unless the opcode says otherwise
        imm       = imm_i;
        reg_wen   = 1'b0;
        mem_wen   = 1'b0;
        mem_rd_en = 1'b0;
        alu_op    = ALU_ADD;
        op1_sel   = OP1_RS1;
        op2_sel   = OP2_IMM;
        wb_sel    = WB_ALU;
        npc_sel   = NPC_SEQ;

        case (opcode)
            OPC_LUI: begin
                imm     = imm_u;
                op1_sel = OP1_ZERO;
                alu_op  = ALU_PASS2;
                reg_wen = 1'b1;
            end
            OPC_AUIPC: begin
                imm     = imm_u;
                op1_sel = OP1_PC;
                reg_wen = 1'b1;
            end
            OPC_JAL: begin
                imm     = imm_j;
                op1_sel = OP1_PC;
                wb_sel  = WB_SNPC;
                npc_sel = NPC_JAL;
                reg_wen = 1'b1;
            end
            OPC_JALR: begin
                wb_sel  = WB_SNPC;
                npc_sel = NPC_JALR;
                reg_wen = 1'b1;
            end
            OPC_BRANCH: begin
                imm     = imm_b;
                op1_sel = OP1_PC;
                npc_sel = NPC_BRANCH;
            end
            OPC_LOAD: begin
                // LD only
                if (funct3 == 3'b011) begin
                    wb_sel    = WB_MEM;
                    mem_rd_en = 1'b1;
                    reg_wen   = 1'b1;
                end
            end
            OPC_STORE: begin
                imm     = imm_s;
                mem_wen = (funct3 == 3'b011);
            end
            OPC_OP_IMM: begin
                alu_op  = arith_op(funct3, 1'b0);
                reg_wen = 1'b1;
            end
            OPC_OP: begin
                op2_sel = OP2_RS2;
                alu_op  = arith_op(funct3, alt);
                reg_wen = 1'b1;
            end
            OPC_OP_IMM_32: begin
                alu_op  = word_op(funct3, 1'b0);
                reg_wen = 1'b1;
            end
            OPC_OP_32: begin
                op2_sel = OP2_RS2;
                alu_op  = word_op(funct3, alt);
                reg_wen = 1'b1;
            end
            default: begin
                op1_sel = OP1_ZERO;
            end
        endcase
    end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

`include "rv64_core_defs.svh"

module alu (
    input  logic [`XLEN-1:0]        op1,
    input  logic [`XLEN-1:0]        op2,
    input  rv64_core_pkg::alu_op_e  alu_op,
    output logic [`XLEN-1:0]        result
);
    import rv64_core_pkg::*;

    logic [5:0]         shamt;
    logic [4:0]         shamt_w;
    logic [31:0]        word_res;
    logic [`XLEN-1:0]   sum;
    logic [`XLEN-1:0]   diff;

    assign shamt   = op2[5:0];
    assign shamt_w = op2[4:0];
    assign sum     = op1 + op2;
    assign diff    = op1 - op2;

    ////////////////////////////////////////
    // Word forms on the low 32 bits
    ////////////////////////////////////////
    always_comb begin
        case (alu_op)
            ALU_SUBW: word_res = diff[31:0];
            ALU_SLLW: word_res = op1[31:0] << shamt_w;
            ALU_SRLW: word_res = op1[31:0] >> shamt_w;
            ALU_SRAW: word_res = $signed(op1[31:0]) >>> shamt_w;
            default:  word_res = sum[31:0];
        endcase
    end

    ////////////////////////////////////////
    // Result select
    ////////////////////////////////////////
    always_comb begin
        case (alu_op)
            ALU_ADD:   result = sum;
            ALU_SUB:   result = diff;
            ALU_SLL:   result = op1 << shamt;
            ALU_SLT:   result = {{(`XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            ALU_SLTU:  result = {{(`XLEN-1){1'b0}}, op1 < op2};
            ALU_XOR:   result = op1 ^ op2;
            ALU_SRL:   result = op1 >> shamt;
            ALU_SRA:   result = $signed(op1) >>> shamt;
            ALU_OR:    result = op1 | op2;
            ALU_AND:   result = op1 & op2;
            ALU_PASS2: result = op2;
            // All word forms share the sign extension
            default:   result = {{(`XLEN-32){word_res[31]}}, word_res};
        endcase
    end

endmodule

// ==== verilog/cpu_top.sv ====
`timescale 1ns/1ps

`include "rv64_core_defs.svh"

module cpu_top (
    input  logic                sys_clk,
    input  logic                rst_n,
    input  logic [31:0]         inst,
    output logic [`XLEN-1:0]    pc,
    output logic [`XLEN-1:0]    mem_addr,
    output logic                mem_rd_en,
    output logic                mem_wen,
    input  logic [`XLEN-1:0]    mem_rd_data,
    output logic [`XLEN-1:0]    mem_wr_data
);
    import rv64_core_pkg::*;

    logic [`XLEN-1:0]   snpc, imm, rs1_data, rs2_data;
    logic [`XLEN-1:0]   alu_op1, alu_op2, alu_result, wr_data;
    logic [4:0]         rs1_addr, rs2_addr, rd_addr;
    logic [2:0]         funct3;
    logic               dec_reg_wen, dec_mem_wen, dec_mem_rd_en;
    alu_op_e            alu_op;
    op1_sel_e           op1_sel;
    op2_sel_e           op2_sel;
    wb_sel_e            wb_sel;
    npc_sel_e           npc_sel;

    pc_unit u_pc_unit (
        .sys_clk(sys_clk), .rst_n(rst_n), .npc_sel(npc_sel), .funct3(funct3),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .target(alu_result),
        .pc(pc), .snpc(snpc)
    );

    // No register write while in reset
    gpr u_gpr (
        .sys_clk(sys_clk), .rst_n(rst_n), .wen(dec_reg_wen & rst_n),
        .rd_addr(rd_addr), .wr_data(wr_data),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    decoder u_decoder (
        .inst(inst), .imm(imm),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
        .funct3(funct3), .reg_wen(dec_reg_wen), .mem_wen(dec_mem_wen),
        .mem_rd_en(dec_mem_rd_en), .alu_op(alu_op), .op1_sel(op1_sel),
        .op2_sel(op2_sel), .wb_sel(wb_sel), .npc_sel(npc_sel)
    );

    alu u_alu (
        .op1(alu_op1), .op2(alu_op2), .alu_op(alu_op), .result(alu_result)
    );

    ////////////////////////////////////////
    // Operand and write-back selects
    ////////////////////////////////////////
    always_comb begin
        case (op1_sel)
            OP1_PC:   alu_op1 = pc;
            OP1_ZERO: alu_op1 = '0;
            default:  alu_op1 = rs1_data;
        endcase
    end

    assign alu_op2 = (op2_sel == OP2_IMM) ? imm : rs2_data;

    always_comb begin
        case (wb_sel)
            WB_MEM:  wr_data = mem_rd_data;
            WB_SNPC: wr_data = snpc;
            default: wr_data = alu_result;
        endcase
    end

    // Memory port, address is always rs1 plus offset
    assign mem_addr    = alu_result;
    assign mem_wr_data = rs2_data;
    assign mem_wen     = dec_mem_wen & rst_n;
    assign mem_rd_en   = dec_mem_rd_en & rst_n;

endmodule

// ==== verification/cpu_top_assertions.sv ====
`timescale 1ns/1ps

`include "rv64_core_defs.svh"

module cpu_top_assertions (
    input logic                sys_clk,
    input logic                rst_n,
    input logic [`XLEN-1:0]    pc,
    input logic [`XLEN-1:0]    mem_addr,
    input logic                mem_rd_en,
    input logic                mem_wen
);

    // Fetch stays word aligned
    pc_aligned: assert property (@(posedge sys_clk) pc[1:0] == 2'b00)
        else $error("pc not a multiple of 4");

    strobes_exclusive: assert property (@(posedge sys_clk) !(mem_wen && mem_rd_en))
        else $error("mem_wen and mem_rd_en both high");

    // Doubleword accesses only
    addr_aligned: assert property (@(posedge sys_clk)
        (mem_wen || mem_rd_en) |-> mem_addr[2:0] == 3'b000)
        else $error("memory address not 8-byte aligned");

    reset_quiet: assert property (@(posedge sys_clk) !rst_n |-> !mem_wen && !mem_rd_en)
        else $error("memory strobe high during reset");

endmodule

bind cpu_top cpu_top_assertions u_assertions (
    .sys_clk(sys_clk), .rst_n(rst_n), .pc(pc), .mem_addr(mem_addr),
    .mem_rd_en(mem_rd_en), .mem_wen(mem_wen)
);

// ==== verification/cpu_top_tb.sv ====
`timescale 1ns/1ps

`include "rv64_core_defs.svh"

module cpu_top_tb;

    logic               sys_clk;
    logic               rst_n;
    logic [31:0]        inst;
    logic [`XLEN-1:0]   pc;
    logic [`XLEN-1:0]   mem_addr;
    logic               mem_rd_en;
    logic               mem_wen;
    logic [`XLEN-1:0]   mem_rd_data;
    logic [`XLEN-1:0]   mem_wr_data;

    logic [31:0]        imem [0:255];
    string              names [0:255];
    logic [`XLEN-1:0]   dmem [0:255];
    logic [`XLEN-1:0]   exp_mem [0:255];
    logic [`XLEN-1:0]   m_regs [0:`REG_COUNT-1];
    logic [`XLEN-1:0]   m_pc, nxt, ea, ed, la, halt_pc;
    logic               est, eld, done;
    int                 seed, prog_len, st_off, errors, checks, cycles, limit, idx;

    cpu_top uut (
        .sys_clk(sys_clk), .rst_n(rst_n), .inst(inst), .pc(pc),
        .mem_addr(mem_addr), .mem_rd_en(mem_rd_en), .mem_wen(mem_wen),
        .mem_rd_data(mem_rd_data), .mem_wr_data(mem_wr_data)
    );

    always #4 sys_clk = ~sys_clk;

    // Zero-wait memories
    assign inst        = imem[pc[9:2]];
    assign mem_rd_data = dmem[mem_addr[10:3]];

    always @(posedge sys_clk) begin
        if (mem_wen)
            dmem[mem_addr[10:3]] <= mem_wr_data;
    end

    ////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs1,
        input logic [4:0] rs2, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] word, input string name);
        imem[prog_len] = word;
        names[prog_len] = name;
        prog_len++;
    endtask

    // Exposes a register through the next free store slot
    task automatic expose(input logic [4:0] rs, input string name);
        emit(enc_s(st_off[11:0], rs, 5'd0), name);
        st_off += 8;
    endtask

    ////////////////////////////////////////
    // ISA reference model
    ////////////////////////////////////////
    function automatic logic [63:0] calc_op(input logic [2:0] f3, input logic alt,
        input logic [63:0] a, input logic [63:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[5:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'b011:  return (a < b) ? 64'd1 : 64'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt)
                    return $signed(a) >>> b[5:0];
                else
                    return a >> b[5:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [63:0] calc_word(input logic [2:0] f3, input logic alt,
        input logic [63:0] a, input logic [63:0] b);
        logic [31:0] w;
        case (f3)
            3'b001:  w = a[31:0] << b[4:0];
            3'b101: begin
                if (alt)
                    w = $signed(a[31:0]) >>> b[4:0];
                else
                    w = a[31:0] >> b[4:0];
            end
            default: w = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
        endcase
        return {{32{w[31]}}, w};
    endfunction

    function automatic logic [63:0] ref_step(input logic [31:0] ins, input logic [63:0] cur,
        output logic st, output logic [63:0] st_addr, output logic [63:0] st_data,
        output logic ld, output logic [63:0] ld_addr);
        logic [63:0] a, b, i_imm, s_imm, b_imm, u_imm, j_imm, res, npc;
        logic        wr, taken;
        a     = m_regs[ins[19:15]];
        b     = m_regs[ins[24:20]];
        i_imm = {{52{ins[31]}}, ins[31:20]};
        s_imm = {{52{ins[31]}}, ins[31:25], ins[11:7]};
        b_imm = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        u_imm = {{32{ins[31]}}, ins[31:12], 12'b0};
        j_imm = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        npc = cur + 64'd4;
        wr = 1'b1;
        st = 1'b0;
        st_addr = '0;
        st_data = '0;
        ld = 1'b0;
        ld_addr = '0;
        res = '0;
        case (ins[6:0])
            7'b0110111: res = u_imm;
            7'b0010111: res = cur + u_imm;
            7'b1101111: begin
                res = cur + 64'd4;
                npc = cur + j_imm;
            end
            7'b1100111: begin
                res = cur + 64'd4;
                npc = (a + i_imm) & ~64'd1;
            end
            7'b1100011: begin
                wr = 1'b0;
                case (ins[14:12])
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken)
                    npc = cur + b_imm;
            end
            7'b0000011: begin
                ld = 1'b1;
                ld_addr = a + i_imm;
                res = exp_mem[ld_addr[10:3]];
            end
            7'b0100011: begin
                wr = 1'b0;
                st = 1'b1;
                st_addr = a + s_imm;
                st_data = b;
                exp_mem[st_addr[10:3]] = b;
            end
            7'b0010011: res = calc_op(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, i_imm);
            7'b0110011: res = calc_op(ins[14:12], ins[30], a, b);
            7'b0011011: res = calc_word(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, i_imm);
            7'b0111011: res = calc_word(ins[14:12], ins[30], a, b);
            default:    wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0)
            m_regs[ins[11:7]] = res;
        return npc;
    endfunction

    ////////////////////////////////////////
    // Program and memory setup
    ////////////////////////////////////////
    initial begin
        sys_clk = 1'b0;
        rst_n = 1'b0;
        seed = 45;
        prog_len = 0;
        st_off = 512;
        errors = 0;
        checks = 0;
        cycles = 0;
        done = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0000_0013;
            names[i] = "nop";
            dmem[i] = {32'hd0d0_0000, 24'h0, i[7:0]};
        end
        for (int i = 0; i < 8; i++)
            dmem[i] = {$random(seed), $random(seed)};
        for (int i = 0; i < 256; i++)
            exp_mem[i] = dmem[i];
        for (int i = 0; i < `REG_COUNT; i++)
            m_regs[i] = '0;
        m_pc = `RESET_PC;

        // Random operands into x1..x8
        for (int i = 1; i <= 8; i++)
            emit(enc_i(i * 8 - 8, 5'd0, 3'b011, i[4:0], 7'b0000011), "seed_load");
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd9, 7'b0110011), "alu_reg");
        expose(5'd9, "alu_reg");
        emit(enc_r(7'h20, 5'd4, 5'd3, 3'b000, 5'd9, 7'b0110011), "alu_reg");
        expose(5'd9, "alu_reg");
        emit(enc_r(7'h20, 5'd6, 5'd5, 3'b101, 5'd9, 7'b0110011), "alu_reg");
        expose(5'd9, "alu_reg");
        for (int f = 1; f < 8; f++) begin
            if (f != 5) begin
                emit(enc_r(7'h00, 5'd7, 5'd8, f[2:0], 5'd10, 7'b0110011), "alu_reg");
                expose(5'd10, "alu_reg");
            end
        end
        emit(enc_r(7'h00, 5'd1, 5'd2, 3'b101, 5'd10, 7'b0110011), "alu_reg");
        expose(5'd10, "alu_reg");
        emit(enc_i(12'hffb, 5'd1, 3'b000, 5'd11, 7'b0010011), "alu_imm");
        expose(5'd11, "alu_imm");
        emit(enc_i(12'h40d, 5'd2, 3'b101, 5'd11, 7'b0010011), "alu_imm");
        expose(5'd11, "alu_imm");
        emit(enc_i(12'h123, 5'd3, 3'b010, 5'd11, 7'b0010011), "alu_imm");
        expose(5'd11, "alu_imm");
        emit(enc_i(12'h800, 5'd4, 3'b011, 5'd11, 7'b0010011), "alu_imm");
        expose(5'd11, "alu_imm");

        // Word forms
        emit(enc_i(12'h064, 5'd3, 3'b000, 5'd12, 7'b0011011), "word_ops");
        expose(5'd12, "word_ops");
        emit(enc_r(7'h20, 5'd5, 5'd4, 3'b000, 5'd12, 7'b0111011), "word_ops");
        expose(5'd12, "word_ops");
        emit(enc_r(7'h20, 5'd7, 5'd6, 3'b101, 5'd12, 7'b0111011), "word_ops");
        expose(5'd12, "word_ops");

        // Reload and store again, x0 stays zero
        emit(enc_i(12'h008, 5'd0, 3'b011, 5'd0, 7'b0000011), "load_store");
        expose(5'd0, "load_store");
        emit(enc_i(12'h010, 5'd0, 3'b011, 5'd13, 7'b0000011), "load_store");
        expose(5'd13, "load_store");

        // Each branch type forward over one increment
        for (int k = 0; k < 6; k++) begin
            idx = (k < 2) ? k : k + 2;
            emit(enc_b(13'd8, 5'd1, 5'd2, idx[2:0]), "branch");
            emit(enc_i(12'h001, 5'd20, 3'b000, 5'd20, 7'b0010011), "branch");
            emit(enc_b(13'd8, 5'd2, 5'd1, idx[2:0]), "branch");
            emit(enc_i(12'h002, 5'd20, 3'b000, 5'd20, 7'b0010011), "branch");
            emit(enc_b(13'd8, 5'd1, 5'd1, idx[2:0]), "branch");
            emit(enc_i(12'h004, 5'd20, 3'b000, 5'd20, 7'b0010011), "branch");
        end
        expose(5'd20, "branch");

        // JAL, then JALR with an odd offset
        emit(enc_j(21'd8, 5'd21), "jump");
        emit(enc_i(12'h001, 5'd20, 3'b000, 5'd20, 7'b0010011), "jump");
        expose(5'd21, "jump");
        emit({20'h00000, 5'd22, 7'b0010111}, "jump");
        emit(enc_i(12'd13, 5'd22, 3'b000, 5'd23, 7'b1100111), "jump");
        emit(enc_i(12'h001, 5'd20, 3'b000, 5'd20, 7'b0010011), "jump");
        expose(5'd23, "jump");
        expose(5'd20, "jump");

        emit({20'habcde, 5'd24, 7'b0110111}, "upper_imm");
        expose(5'd24, "upper_imm");
        emit({20'h12345, 5'd25, 7'b0010111}, "upper_imm");
        expose(5'd25, "upper_imm");

        // Self loop marks the end
        halt_pc = prog_len * 4;
        emit(enc_j(21'd0, 5'd0), "halt");
        limit = 2 * prog_len + 20;

        repeat (3) @(posedge sys_clk);
        #1 rst_n = 1'b1;
        wait (done);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    ////////////////////////////////////////
    // Compare against the model
    ////////////////////////////////////////
    always @(negedge sys_clk) begin
        if (rst_n && !done) begin
            idx = m_pc[9:2];
            checks++;
            if (pc !== m_pc) begin
                errors++;
                $display("FAILED %s pc: expected %h actual %h", names[idx], m_pc, pc);
            end
            nxt = ref_step(imem[idx], m_pc, est, ea, ed, eld, la);
            if (est) begin
                if (mem_wen !== 1'b1) begin
                    errors++;
                    $display("FAILED %s mem_wen: expected 1 actual %b", names[idx], mem_wen);
                end
                if (mem_addr !== ea) begin
                    errors++;
                    $display("FAILED %s mem_addr: expected %h actual %h",
                             names[idx], ea, mem_addr);
                end
                if (mem_wr_data !== ed) begin
                    errors++;
                    $display("FAILED %s mem_wr_data: expected %h actual %h",
                             names[idx], ed, mem_wr_data);
                end
            end else if (mem_wen !== 1'b0) begin
                errors++;
                $display("FAILED %s mem_wen: expected 0 actual %b", names[idx], mem_wen);
            end
            if (eld) begin
                if (mem_rd_en !== 1'b1) begin
                    errors++;
                    $display("FAILED %s mem_rd_en: expected 1 actual %b",
                             names[idx], mem_rd_en);
                end
                if (mem_addr !== la) begin
                    errors++;
                    $display("FAILED %s mem_addr: expected %h actual %h",
                             names[idx], la, mem_addr);
                end
            end else if (mem_rd_en !== 1'b0) begin
                errors++;
                $display("FAILED %s mem_rd_en: expected 0 actual %b", names[idx], mem_rd_en);
            end
            if (m_pc == halt_pc)
                done = 1'b1;
            else
                m_pc = nxt;
        end
    end

    always @(posedge sys_clk) begin
        cycles++;
        if (cycles > limit + 3 && !done) begin
            errors++;
            $display("Run did not reach the end of the program within %0d cycles", limit);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

endmodule

// ==== rv64_core.f ====
+incdir+include
verilog/rv64_core_pkg.sv
verilog/pc_unit.sv
verilog/gpr.sv
verilog/decoder.sv
verilog/alu.sv
verilog/cpu_top.sv
verification/cpu_top_assertions.sv
verification/cpu_top_tb.sv
